/* hw/fe_pkg.sv */
package fe_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // stall vector, one bit per frozen point
    localparam int stall_w  = 3;
    localparam int stall_pc = 0;  // fetch unit
    localparam int stall_if = 1;  // fetch to if/id handoff
    localparam int stall_id = 2;  // if/id register

    // fetch fsm encoding
    localparam int             state_w = 2;
    localparam logic [state_w-1:0] st_idle = 2'd0;
    localparam logic [state_w-1:0] st_bus  = 2'd1;
    localparam logic [state_w-1:0] st_hold = 2'd2;  // word held for if/id

    // rv32i major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam int op_class_w = 4;
    localparam logic [op_class_w-1:0] cls_lui     = 4'd0;
    localparam logic [op_class_w-1:0] cls_auipc   = 4'd1;
    localparam logic [op_class_w-1:0] cls_jal     = 4'd2;
    localparam logic [op_class_w-1:0] cls_jalr    = 4'd3;
    localparam logic [op_class_w-1:0] cls_branch  = 4'd4;
    localparam logic [op_class_w-1:0] cls_load    = 4'd5;
    localparam logic [op_class_w-1:0] cls_store   = 4'd6;
    localparam logic [op_class_w-1:0] cls_op_imm  = 4'd7;
    localparam logic [op_class_w-1:0] cls_op      = 4'd8;
    localparam logic [op_class_w-1:0] cls_system  = 4'd9;
    localparam logic [op_class_w-1:0] cls_illegal = 4'd15;

    // one instruction word, seen through each rv32i format
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_u;

endpackage

/* hw/fetch_if.sv */
`timescale 1ns/1ns

// handoff of one fetched word from the fetch unit to if/id
interface fetch_if;

    logic                    valid;  // word held by fetch
    logic [fe_pkg::xlen-1:0] pc;
    fe_pkg::inst_u           inst;
    logic                    ready;  // if/id takes it

    modport src (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport dst (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );

endinterface

/* hw/pc_fetch.sv */
`timescale 1ns/1ns

module pc_fetch (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [fe_pkg::stall_w-1:0] stall,
    input  logic                       redirect_valid,
    input  logic [fe_pkg::xlen-1:0]    redirect_pc,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [3:0]                 wb_sel,
    output logic [fe_pkg::xlen-1:0]    wb_adr,
    input  logic [fe_pkg::xlen-1:0]    wb_dat_i,
    input  logic                       wb_ack,
    fetch_if.src                       fetch,
    output logic                       fetch_wait
);

    logic [fe_pkg::state_w-1:0] state;
    logic [fe_pkg::xlen-1:0]    pc;       // address of the next word in program order
    logic [fe_pkg::xlen-1:0]    adr_q;    // address of the open or held word
    fe_pkg::inst_u              inst_q;
    logic                       discard;  // open cycle belongs to an old path
    logic                       take;
    logic                       start;
    logic [fe_pkg::xlen-1:0]    next_pc;

    // word handed to if/id on this edge
    assign take = fetch.valid && fetch.ready && !stall[fe_pkg::stall_pc];

    // redirect beats the normal advance
    assign next_pc = redirect_valid ? redirect_pc :
                     take           ? pc + 32'd4  : pc;

    // a new bus cycle opens after reset, after a dropped cycle,
    // after a transfer, or when a held word is dropped by a redirect
    assign start = (state == fe_pkg::st_idle) ||
                   ((state == fe_pkg::st_hold) && (take || redirect_valid));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= fe_pkg::st_idle;
            pc      <= fe_pkg::reset_pc;
            discard <= 1'b0;
        end else begin
            pc <= next_pc;
            case (state)
                fe_pkg::st_idle: begin
                    state <= fe_pkg::st_bus;
                end
                fe_pkg::st_bus: begin
                    if (wb_ack) begin
                        // stale data is thrown away, cyc drops either way
                        if (discard || redirect_valid) begin
                            state <= fe_pkg::st_idle;
                        end else begin
                            state <= fe_pkg::st_hold;
                        end
                        discard <= 1'b0;
                    end else if (redirect_valid) begin
                        discard <= 1'b1;  // let the cycle finish
                    end
                end
                fe_pkg::st_hold: begin
                    if (start) begin
                        state <= fe_pkg::st_bus;
                    end
                end
                default: begin
                    state <= fe_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= next_pc;  // stable for the whole bus cycle
        end
        if ((state == fe_pkg::st_bus) && wb_ack) begin
            inst_q.raw <= wb_dat_i;
        end
    end

    // classic wishbone, read only, one cycle at a time
    assign wb_cyc = (state == fe_pkg::st_bus);
    assign wb_stb = (state == fe_pkg::st_bus);
    assign wb_we  = 1'b0;
    assign wb_sel = 4'hf;
    assign wb_adr = adr_q;

    assign fetch.valid = (state == fe_pkg::st_hold);
    assign fetch.pc    = adr_q;
    assign fetch.inst  = inst_q;

    assign fetch_wait = (state != fe_pkg::st_hold);

endmodule

/* hw/stall_ctrl.sv */
`timescale 1ns/1ns

module stall_ctrl (
    input  logic                       back_stall,
    input  logic                       fetch_wait,
    input  logic                       redirect_valid,
    output logic [fe_pkg::stall_w-1:0] stall,
    output logic                       flush
);

    // flush wins over everything else
    assign flush = redirect_valid;

    always_comb begin
        stall = '0;
        if (redirect_valid) begin
            // no handoff while the old path is thrown away
            stall[fe_pkg::stall_if] = 1'b1;
        end else if (back_stall) begin
            stall[fe_pkg::stall_id] = 1'b1;  // freeze decode outputs
            stall[fe_pkg::stall_if] = 1'b1;
        end else if (fetch_wait) begin
            // no word yet, bubble into if/id
            stall[fe_pkg::stall_pc] = 1'b1;
        end
    end

endmodule

/* hw/if_id.sv */
`timescale 1ns/1ns

module if_id (
    input  logic                       clk,
    input  logic                       arst_n,
    fetch_if.dst                       fetch,
    input  logic [fe_pkg::stall_w-1:0] stall,
    input  logic                       flush,
    output logic                       id_valid,
    output logic [fe_pkg::xlen-1:0]    id_pc,
    output fe_pkg::inst_u              id_inst
);

    // handoff blocked whenever the interface stage is frozen
    assign fetch.ready = !stall[fe_pkg::stall_if];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else if (flush) begin
            // wrong path, drop the entry
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else if (stall[fe_pkg::stall_id]) begin
            id_valid <= id_valid;  // back end not taking it
            id_pc    <= id_pc;
            id_inst  <= id_inst;
        end else if (stall[fe_pkg::stall_pc]) begin
            // nothing fetched yet, bubble
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else begin
            id_valid <= fetch.valid;
            id_pc    <= fetch.pc;
            id_inst  <= fetch.inst;
        end
    end

endmodule

/* hw/inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
    input  fe_pkg::inst_u                 id_inst,
    output logic [fe_pkg::op_class_w-1:0] op_class,
    output logic [4:0]                    rd,
    output logic [4:0]                    rs1,
    output logic [4:0]                    rs2,
    output logic [fe_pkg::xlen-1:0]       imm
);

    logic [fe_pkg::xlen-1:0] imm_i;
    logic [fe_pkg::xlen-1:0] imm_s;
    logic [fe_pkg::xlen-1:0] imm_b;
    logic [fe_pkg::xlen-1:0] imm_u;
    logic [fe_pkg::xlen-1:0] imm_j;

    // immediates for each format, sign taken from bit 31
    assign imm_i = {{20{id_inst.i.imm_11_0[11]}}, id_inst.i.imm_11_0};
    assign imm_s = {{20{id_inst.s.imm_11_5[6]}}, id_inst.s.imm_11_5, id_inst.s.imm_4_0};
    assign imm_b = {{19{id_inst.b.imm_12}}, id_inst.b.imm_12, id_inst.b.imm_11,
                    id_inst.b.imm_10_5, id_inst.b.imm_4_1, 1'b0};
    assign imm_u = {id_inst.u.imm_31_12, 12'h000};
    assign imm_j = {{11{id_inst.j.imm_20}}, id_inst.j.imm_20, id_inst.j.imm_19_12,
                    id_inst.j.imm_11, id_inst.j.imm_10_1, 1'b0};

    always_comb begin
        op_class = fe_pkg::cls_illegal;
        rd       = 5'd0;
        rs1      = 5'd0;
        rs2      = 5'd0;
        imm      = '0;
        case (id_inst.r.opcode)
            fe_pkg::op_lui, fe_pkg::op_auipc: begin
                op_class = (id_inst.r.opcode == fe_pkg::op_lui) ? fe_pkg::cls_lui :
                                                                  fe_pkg::cls_auipc;
                rd  = id_inst.u.rd;
                imm = imm_u;
            end
            fe_pkg::op_jal: begin
                op_class = fe_pkg::cls_jal;
                rd       = id_inst.j.rd;
                imm      = imm_j;
            end
            fe_pkg::op_jalr, fe_pkg::op_load, fe_pkg::op_op_imm, fe_pkg::op_system: begin
                case (id_inst.r.opcode)
                    fe_pkg::op_jalr:  op_class = fe_pkg::cls_jalr;
                    fe_pkg::op_load:  op_class = fe_pkg::cls_load;
                    fe_pkg::op_op_imm: op_class = fe_pkg::cls_op_imm;
                    default:          op_class = fe_pkg::cls_system;
                endcase
                rd  = id_inst.i.rd;
                rs1 = id_inst.i.rs1;
                imm = imm_i;
            end
            fe_pkg::op_branch: begin
                op_class = fe_pkg::cls_branch;
                rs1      = id_inst.b.rs1;
                rs2      = id_inst.b.rs2;
                imm      = imm_b;
            end
            fe_pkg::op_store: begin
                op_class = fe_pkg::cls_store;
                rs1      = id_inst.s.rs1;
                rs2      = id_inst.s.rs2;
                imm      = imm_s;
            end
            fe_pkg::op_op: begin
                op_class = fe_pkg::cls_op;  // r format, no immediate
                rd       = id_inst.r.rd;
                rs1      = id_inst.r.rs1;
                rs2      = id_inst.r.rs2;
            end
            default: begin
                op_class = fe_pkg::cls_illegal;
            end
        endcase
    end

endmodule

/* hw/front_end_top.sv */
`timescale 1ns/1ns

module front_end_top (
    input  logic                          clk,
    input  logic                          arst_n,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [3:0]                    wb_sel,
    output logic [fe_pkg::xlen-1:0]       wb_adr,
    input  logic [fe_pkg::xlen-1:0]       wb_dat_i,
    input  logic                          wb_ack,
    input  logic                          redirect_valid,
    input  logic [fe_pkg::xlen-1:0]       redirect_pc,
    input  logic                          back_stall,
    output logic                          id_valid,
    output logic [fe_pkg::xlen-1:0]       id_pc,
    output logic [fe_pkg::op_class_w-1:0] op_class,
    output logic [4:0]                    rd,
    output logic [4:0]                    rs1,
    output logic [4:0]                    rs2,
    output logic [fe_pkg::xlen-1:0]       imm
);

    logic [fe_pkg::stall_w-1:0] stall;
    logic                       flush;
    logic                       fetch_wait;
    fe_pkg::inst_u              id_inst;

    fetch_if fetch_bus ();

    pc_fetch pc_fetch_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_sel         (wb_sel),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .fetch          (fetch_bus.src),
        .fetch_wait     (fetch_wait)
    );

    stall_ctrl stall_ctrl_inst (
        .back_stall     (back_stall),
        .fetch_wait     (fetch_wait),
        .redirect_valid (redirect_valid),
        .stall          (stall),
        .flush          (flush)
    );

    if_id if_id_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .fetch    (fetch_bus.dst),
        .stall    (stall),
        .flush    (flush),
        .id_valid (id_valid),
        .id_pc    (id_pc),
        .id_inst  (id_inst)
    );

    inst_decode inst_decode_inst (
        .id_inst  (id_inst),
        .op_class (op_class),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm)
    );

endmodule

/* tb/front_end_asserts.sv */
`timescale 1ns/1ns

module front_end_asserts (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic [fe_pkg::xlen-1:0] wb_adr,
    input logic                    wb_ack,
    input logic                    redirect_valid,
    input logic                    id_valid
);

    int err_count = 0;  // read by the testbench

    // request held until the slave answers
    stb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else begin
            $error("stb or adr changed before ack");
            err_count++;
        end

    // classic cycle closes right after the ack
    ack_ends_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !(wb_cyc || wb_stb))
        else begin
            $error("cyc or stb still high after ack");
            err_count++;
        end

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> !id_valid)
        else begin
            $error("id_valid high after flush");
            err_count++;
        end

endmodule

/* tb/tb_front_end.sv */
`timescale 1ns/1ns

module tb_front_end #(
    parameter int seed = 82736
);

    localparam int n_checks = 300;  // decoded words compared before the end
    localparam int n_budget = 400;  // instructions allowed by the watchdog
    localparam int clk_ns   = 8;

    logic                          clk;
    logic                          arst_n;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [3:0]                    wb_sel;
    logic [fe_pkg::xlen-1:0]       wb_adr;
    logic [fe_pkg::xlen-1:0]       wb_dat_i;
    logic                          wb_ack;
    logic                          redirect_valid;
    logic [fe_pkg::xlen-1:0]       redirect_pc;
    logic                          back_stall;
    logic                          id_valid;
    logic [fe_pkg::xlen-1:0]       id_pc;
    logic [fe_pkg::op_class_w-1:0] op_class;
    logic [4:0]                    rd;
    logic [4:0]                    rs1;
    logic [4:0]                    rs2;
    logic [fe_pkg::xlen-1:0]       imm;

    logic [31:0] mem [0:255];
    logic [6:0]  legal_ops [0:9];
    int          wait_cnt;
    int          n_done;
    int          iter;
    logic [31:0] exp_pc;        // model pc in program order
    logic        held;          // outputs must not move on the next edge
    logic [63:0] snap;
    logic [31:0] snap_imm;
    logic [3:0]  e_cls;
    logic [4:0]  e_rd;
    logic [4:0]  e_rs1;
    logic [4:0]  e_rs2;
    logic [31:0] e_imm;

    front_end_top front_end_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_sel         (wb_sel),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .back_stall     (back_stall),
        .id_valid       (id_valid),
        .id_pc          (id_pc),
        .op_class       (op_class),
        .rd             (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm)
    );

    bind front_end_top front_end_asserts front_end_asserts_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack),
        .redirect_valid (redirect_valid),
        .id_valid       (id_valid)
    );

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // decoder model written from the rv32i bit positions
    function automatic void ref_decode(input logic [31:0] w, output logic [3:0] cls,
                                       output logic [4:0] d, output logic [4:0] s1,
                                       output logic [4:0] s2, output logic [31:0] im);
        cls = fe_pkg::cls_illegal;
        d   = 5'd0;
        s1  = 5'd0;
        s2  = 5'd0;
        im  = 32'd0;
        case (w[6:0])
            fe_pkg::op_lui, fe_pkg::op_auipc: begin
                cls = (w[6:0] == fe_pkg::op_lui) ? fe_pkg::cls_lui : fe_pkg::cls_auipc;
                d   = w[11:7];
                im  = {w[31:12], 12'd0};
            end
            fe_pkg::op_jal: begin
                cls = fe_pkg::cls_jal;
                d   = w[11:7];
                im  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            fe_pkg::op_jalr, fe_pkg::op_load, fe_pkg::op_op_imm, fe_pkg::op_system: begin
                if (w[6:0] == fe_pkg::op_jalr) cls = fe_pkg::cls_jalr;
                else if (w[6:0] == fe_pkg::op_load) cls = fe_pkg::cls_load;
                else if (w[6:0] == fe_pkg::op_op_imm) cls = fe_pkg::cls_op_imm;
                else cls = fe_pkg::cls_system;
                d  = w[11:7];
                s1 = w[19:15];
                im = {{20{w[31]}}, w[31:20]};
            end
            fe_pkg::op_branch: begin
                cls = fe_pkg::cls_branch;
                s1  = w[19:15];
                s2  = w[24:20];
                im  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            fe_pkg::op_store: begin
                cls = fe_pkg::cls_store;
                s1  = w[19:15];
                s2  = w[24:20];
                im  = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            fe_pkg::op_op: begin
                cls = fe_pkg::cls_op;
                d   = w[11:7];
                s1  = w[19:15];
                s2  = w[24:20];
            end
            default: begin
                cls = fe_pkg::cls_illegal;
            end
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    initial begin
        #(n_budget * 6 * clk_ns);
        $display("Done: errors found");
        $fatal(1, "watchdog: the run did not finish in time");
    end

    // wishbone slave, 0 to 3 wait states per cycle
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack   = 1'b0;
            wait_cnt = $urandom % 4;  // fresh wait for the next cycle
        end else if (wb_cyc && wb_stb) begin
            if (wait_cnt == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = mem[wb_adr[9:2]];
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end else begin
            wait_cnt = $urandom % 4;
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if (held) begin
                check({31'd0, id_valid}, {31'd0, snap[63]}, "id_valid under stall");
                check(id_pc, snap[62:31], "id_pc under stall");
                check({28'd0, op_class}, {28'd0, snap[30:27]}, "op_class under stall");
                check({17'd0, rd, rs1, rs2}, {17'd0, snap[14:0]}, "registers under stall");
                check(imm, snap_imm, "imm under stall");
            end
            held     = back_stall && !redirect_valid;
            snap     = {id_valid, id_pc, op_class, 12'd0, rd, rs1, rs2};
            snap_imm = imm;
            if (id_valid && !back_stall) begin
                ref_decode(mem[exp_pc[9:2]], e_cls, e_rd, e_rs1, e_rs2, e_imm);
                check(id_pc, exp_pc, "id_pc");
                check({28'd0, op_class}, {28'd0, e_cls}, "op_class");
                check({27'd0, rd}, {27'd0, e_rd}, "rd");
                check({27'd0, rs1}, {27'd0, e_rs1}, "rs1");
                check({27'd0, rs2}, {27'd0, e_rs2}, "rs2");
                check(imm, e_imm, "imm");
                exp_pc = exp_pc + 32'd4;
                n_done = n_done + 1;
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc;  // new path starts here
            end
            if (wb_stb) begin
                check({31'd0, wb_we}, 32'd0, "wb_we");
                check({28'd0, wb_sel}, 32'hf, "wb_sel");
                check({30'd0, wb_adr[1:0]}, 32'd0, "wb_adr alignment");
            end
            if (front_end_top_inst.front_end_asserts_inst.err_count != 0) begin
                $display("Done: errors found");
                $fatal(1, "a protocol assertion failed");
            end
        end
    end

    initial begin
        void'($urandom(seed));
        legal_ops[0] = fe_pkg::op_lui;
        legal_ops[1] = fe_pkg::op_auipc;
        legal_ops[2] = fe_pkg::op_jal;
        legal_ops[3] = fe_pkg::op_jalr;
        legal_ops[4] = fe_pkg::op_branch;
        legal_ops[5] = fe_pkg::op_load;
        legal_ops[6] = fe_pkg::op_store;
        legal_ops[7] = fe_pkg::op_op_imm;
        legal_ops[8] = fe_pkg::op_op;
        legal_ops[9] = fe_pkg::op_system;
        for (int a = 0; a < 256; a++) begin
            mem[a] = $urandom;
            if (a % 29 == 11) begin
                mem[a][6:0] = (a % 2 == 1) ? 7'b1111111 : 7'b0000000;  // illegal
            end else begin
                mem[a][6:0] = legal_ops[$urandom % 10];
            end
        end
        arst_n         = 1'b0;
        wb_ack         = 1'b0;
        wb_dat_i       = '0;
        wait_cnt       = 0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        back_stall     = 1'b0;
        n_done         = 0;
        iter           = 0;
        held           = 1'b0;
        snap           = '0;
        snap_imm       = '0;
        exp_pc         = fe_pkg::reset_pc;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        while (n_done < n_checks) begin
            @(negedge clk);
            iter           = iter + 1;
            back_stall     = ($urandom % 5) == 0;
            redirect_valid = 1'b0;
            if (n_done > 20) begin
                // every 60th cycle aim at an open bus cycle
                if (((iter % 60 == 0) && wb_cyc) || ($urandom % 40 == 0)) begin
                    redirect_valid = 1'b1;
                    redirect_pc    = {22'd0, 8'($urandom % 256), 2'b00};
                end
            end
        end
        @(negedge clk);
        back_stall     = 1'b0;
        redirect_valid = 1'b0;
        if (front_end_top_inst.front_end_asserts_inst.err_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "a protocol assertion failed");
        end
    end

endmodule

/* list.f */
hw/fe_pkg.sv
hw/fetch_if.sv
hw/pc_fetch.sv
hw/stall_ctrl.sv
hw/if_id.sv
hw/inst_decode.sv
hw/front_end_top.sv
tb/front_end_asserts.sv
tb/tb_front_end.sv

/* Makefile */
TOP   ?= tb_front_end
FLAGS ?= --assert
SEED  ?= 82736
MDIR  ?= obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing $(FLAGS) --top-module $(TOP) -Gseed=$(SEED) \
		-f list.f --Mdir $(MDIR)
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)
